// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := branch_predictor_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/bht.sv ====
module bht #(
	parameter int entries = bpu_pkg::bht_entries
)(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   flush,

	input  bpu_pkg::virt_t         pc,

	input  logic                   upd_valid,
	input  bpu_pkg::branch_update_t upd,

	output bpu_pkg::bht_predict_t [bpu_pkg::fetch_num-1:0] predict
);

	localparam int rows     = entries / bpu_pkg::fetch_num;
	localparam int row_bits = $clog2(rows);

	typedef logic [row_bits-1:0] row_t;

	typedef struct packed {
		logic              valid;
		bpu_pkg::counter_t counter;
	} entry_t;

	entry_t table_q [rows][bpu_pkg::fetch_num];

	// ========================================
	// lookup.
	// ========================================

	row_t rd_row;

	assign rd_row = pc[bpu_pkg::group_lsb +: row_bits];  // one row per fetch group.

	for (genvar i = 0; i < bpu_pkg::fetch_num; i++) begin : gen_predict
		assign predict[i].valid = table_q[rd_row][i].valid;
		assign predict[i].taken = table_q[rd_row][i].counter[1];
	end

	// ========================================
	// training.
	// ========================================

	row_t            upd_row;
	bpu_pkg::slot_t  upd_slot;

	assign upd_row  = upd.pc[bpu_pkg::group_lsb +: row_bits];
	assign upd_slot = upd.pc[bpu_pkg::inst_offset +: bpu_pkg::slot_bits];

	// taken climbs to 11 from 01 or 10 and not taken falls to 00 except from 11.
	function automatic bpu_pkg::counter_t next_counter(
		input bpu_pkg::counter_t cur,
		input logic              taken
	);
		bpu_pkg::counter_t nxt;
		if (taken) begin
			nxt = (cur == 2'b00) ? 2'b01 : 2'b11;
		end else begin
			nxt = (cur == 2'b11) ? 2'b10 : 2'b00;
		end
		return nxt;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < rows; r++) begin
				for (int s = 0; s < bpu_pkg::fetch_num; s++) begin
					table_q[r][s] <= '0;
				end
			end
		end else if (flush) begin
			// an update in the same cycle is dropped.
			for (int r = 0; r < rows; r++) begin
				for (int s = 0; s < bpu_pkg::fetch_num; s++) begin
					table_q[r][s].valid   <= 1'b0;
					table_q[r][s].counter <= 2'b10;  // weakly taken.
				end
			end
		end else if (upd_valid) begin
			table_q[upd_row][upd_slot].valid   <= 1'b1;
			table_q[upd_row][upd_slot].counter <=
				next_counter(table_q[upd_row][upd_slot].counter, upd.taken);
		end
	end

endmodule

// ==== logic/bpu_pkg.sv ====
package bpu_pkg;

	// ========================================
	// sizes of the predictor.
	// ========================================

	localparam int fetch_num      = 2;   // instructions per fetch group.
	localparam int inst_offset    = 2;   // byte offset bits of one instruction.
	localparam int bht_entries    = 64;
	localparam int btb_entries    = 32;
	localparam int update_sources = 2;   // resolution pipes.

	localparam int slot_bits   = $clog2(fetch_num);
	localparam int group_lsb   = inst_offset + slot_bits;  // lowest pc bit above the group.
	localparam int group_bytes = fetch_num << inst_offset;

	// ========================================
	// types.
	// ========================================

	typedef logic [31:0]          virt_t;
	typedef logic [1:0]           counter_t;
	typedef logic [slot_bits-1:0] slot_t;

	// one resolved branch from a resolution pipe.
	typedef struct packed {
		virt_t pc;
		logic  taken;
		virt_t target;
	} branch_update_t;

	typedef struct packed {
		logic valid;
		logic taken;   // upper counter bit.
	} bht_predict_t;

	typedef struct packed {
		logic  hit;
		virt_t target;
	} btb_predict_t;

	// final per-slot answer to the fetch stage.
	typedef struct packed {
		logic  hit;
		logic  taken;
		virt_t target;
	} fetch_predict_t;

endpackage

// ==== logic/branch_predictor.sv ====
module branch_predictor (
	input  logic clk,
	input  logic rst_n,
	input  logic flush,

	input  bpu_pkg::virt_t pc,

	input  logic [bpu_pkg::update_sources-1:0]                    upd_valid,
	input  bpu_pkg::branch_update_t [bpu_pkg::update_sources-1:0] upd,
	output logic [bpu_pkg::update_sources-1:0]                    upd_ready,

	output bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0] predict,
	output bpu_pkg::virt_t                                   next_pc
);

	logic                    win_valid;
	bpu_pkg::branch_update_t win;

	bpu_pkg::bht_predict_t [bpu_pkg::fetch_num-1:0] bht_pred;
	bpu_pkg::btb_predict_t [bpu_pkg::fetch_num-1:0] btb_pred;

	// ========================================
	// shared update path.
	// ========================================

	update_arbiter u_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.upd_valid (upd_valid),
		.upd       (upd),
		.upd_ready (upd_ready),
		.win_valid (win_valid),
		.win       (win)
	);

	bht #(.entries(bpu_pkg::bht_entries)) u_bht (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.pc        (pc),
		.upd_valid (win_valid),
		.upd       (win),
		.predict   (bht_pred)
	);

	btb #(.entries(bpu_pkg::btb_entries)) u_btb (
		.clk       (clk),
		.rst_n     (rst_n),
		.pc        (pc),
		.upd_valid (win_valid),
		.upd       (win),
		.predict   (btb_pred)
	);

	next_pc_select u_select (
		.pc          (pc),
		.bht_predict (bht_pred),
		.btb_predict (btb_pred),
		.predict     (predict),
		.next_pc     (next_pc)
	);

endmodule

// ==== logic/btb.sv ====
module btb #(
	parameter int entries = bpu_pkg::btb_entries
)(
	input  logic                   clk,
	input  logic                   rst_n,

	input  bpu_pkg::virt_t         pc,

	input  logic                   upd_valid,
	input  bpu_pkg::branch_update_t upd,

	output bpu_pkg::btb_predict_t [bpu_pkg::fetch_num-1:0] predict
);

	localparam int addr_bits  = $bits(bpu_pkg::virt_t);
	localparam int index_bits = $clog2(entries);
	localparam int tag_bits   = addr_bits - bpu_pkg::inst_offset - index_bits;

	typedef logic [index_bits-1:0] index_t;
	typedef logic [tag_bits-1:0]   tag_t;

	logic [entries-1:0] valid_q;
	tag_t               tag_q    [entries];
	bpu_pkg::virt_t     target_q [entries];

	// direct mapped on the instruction word address.
	function automatic index_t index_of(input bpu_pkg::virt_t addr);
		return addr[bpu_pkg::inst_offset +: index_bits];
	endfunction

	function automatic tag_t tag_of(input bpu_pkg::virt_t addr);
		return addr[addr_bits-1 -: tag_bits];
	endfunction

	// ========================================
	// one lookup address per slot.
	// ========================================

	for (genvar i = 0; i < bpu_pkg::fetch_num; i++) begin : gen_lookup
		bpu_pkg::virt_t slot_pc;
		index_t         idx;

		assign slot_pc = {pc[addr_bits-1:bpu_pkg::group_lsb], bpu_pkg::slot_t'(i),
			{bpu_pkg::inst_offset{1'b0}}};
		assign idx     = index_of(slot_pc);

		assign predict[i].hit    = valid_q[idx] && (tag_q[idx] == tag_of(slot_pc));
		assign predict[i].target = target_q[idx];
	end

	// ========================================
	// write on taken branches only.
	// ========================================

	logic   wr_en;
	index_t wr_idx;

	assign wr_en  = upd_valid && upd.taken;
	assign wr_idx = index_of(upd.pc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_q[wr_idx]    <= tag_of(upd.pc);
			target_q[wr_idx] <= upd.target;
		end
	end

endmodule

// ==== logic/next_pc_select.sv ====
module next_pc_select (
	input  bpu_pkg::virt_t                                   pc,
	input  bpu_pkg::bht_predict_t   [bpu_pkg::fetch_num-1:0] bht_predict,
	input  bpu_pkg::btb_predict_t   [bpu_pkg::fetch_num-1:0] btb_predict,
	output bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0] predict,
	output bpu_pkg::virt_t                                   next_pc
);

	// ========================================
	// per-slot decision.
	// ========================================

	for (genvar i = 0; i < bpu_pkg::fetch_num; i++) begin : gen_slot
		assign predict[i].hit    = btb_predict[i].hit;
		assign predict[i].taken  = bht_predict[i].valid && bht_predict[i].taken
			&& btb_predict[i].hit;   // a redirect needs a target.
		assign predict[i].target = btb_predict[i].target;
	end

	// ========================================
	// next fetch pc.
	// ========================================

	bpu_pkg::virt_t group_pc;
	bpu_pkg::virt_t seq_pc;

	assign group_pc = {pc[$bits(bpu_pkg::virt_t)-1:bpu_pkg::group_lsb],
		{bpu_pkg::group_lsb{1'b0}}};
	assign seq_pc   = group_pc + bpu_pkg::virt_t'(bpu_pkg::group_bytes);

	// scanned from the top so the lowest taken slot wins.
	always_comb begin
		next_pc = seq_pc;
		for (int i = bpu_pkg::fetch_num - 1; i >= 0; i--) begin
			if (predict[i].taken) begin
				next_pc = predict[i].target;
			end
		end
	end

endmodule

// ==== logic/update_arbiter.sv ====
module update_arbiter (
	input  logic clk,
	input  logic rst_n,

	input  logic [bpu_pkg::update_sources-1:0]                    upd_valid,
	input  bpu_pkg::branch_update_t [bpu_pkg::update_sources-1:0] upd,
	output logic [bpu_pkg::update_sources-1:0]                    upd_ready,

	output logic                    win_valid,
	output bpu_pkg::branch_update_t win
);

	// ========================================
	// round-robin grant between two pipes.
	// ========================================

	logic prio_q;     // source that wins the next conflict.
	logic conflict;
	logic win_sel;

	assign conflict = upd_valid[0] && upd_valid[1];

	always_comb begin
		upd_ready = '0;
		if (conflict) begin
			upd_ready[prio_q] = 1'b1;
		end else begin
			upd_ready = upd_valid;  // a lone request is always granted.
		end
	end

	assign win_sel   = upd_ready[1];
	assign win_valid = |upd_valid;
	assign win       = upd[win_sel];

	// only a contested grant moves the priority.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_q <= 1'b0;
		end else if (conflict) begin
			prio_q <= ~prio_q;
		end
	end

endmodule

// ==== tb.f ====
logic/bpu_pkg.sv
logic/bht.sv
logic/btb.sv
logic/update_arbiter.sv
logic/next_pc_select.sv
logic/branch_predictor.sv
verif/tb_clock.sv
verif/branch_predictor_properties.sv
verif/branch_predictor_checker.sv
verif/branch_predictor_tb.sv

// ==== verif/branch_predictor_checker.sv ====
module branch_predictor_checker (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic                                                  flush,
	input  bpu_pkg::virt_t                                        pc,
	input  logic [bpu_pkg::update_sources-1:0]                    upd_valid,
	input  bpu_pkg::branch_update_t [bpu_pkg::update_sources-1:0] upd,
	input  logic [bpu_pkg::update_sources-1:0]                    upd_ready,
	input  bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0]      predict,
	input  bpu_pkg::virt_t                                        next_pc,
	output int                                                    pred_errors,
	output int                                                    ready_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int hist_rows = bpu_pkg::bht_entries / bpu_pkg::fetch_num;

	// mirror of both tables.
	logic              hist_valid [hist_rows][bpu_pkg::fetch_num];
	bpu_pkg::counter_t hist_cnt   [hist_rows][bpu_pkg::fetch_num];
	logic              tgt_valid  [bpu_pkg::btb_entries];
	bpu_pkg::virt_t    tgt_tag    [bpu_pkg::btb_entries];
	bpu_pkg::virt_t    tgt_addr   [bpu_pkg::btb_entries];
	logic              prio;   // source that wins the next conflict.
	int                n_pred = 0;
	int                n_ready = 0;

	assign pred_errors  = n_pred;
	assign ready_errors = n_ready;

	function automatic int hist_row(input bpu_pkg::virt_t a);
		return int'((a / bpu_pkg::group_bytes) % hist_rows);
	endfunction

	function automatic int btb_index(input bpu_pkg::virt_t a);
		return int'((a >> bpu_pkg::inst_offset) % bpu_pkg::btb_entries);
	endfunction

	function automatic bpu_pkg::virt_t btb_tag(input bpu_pkg::virt_t a);
		return a >> (bpu_pkg::inst_offset + $clog2(bpu_pkg::btb_entries));
	endfunction

	function automatic bpu_pkg::counter_t train(input bpu_pkg::counter_t c, input logic tk);
		case (c)
			2'b00:   return tk ? 2'b01 : 2'b00;
			2'b11:   return tk ? 2'b11 : 2'b10;
			default: return tk ? 2'b11 : 2'b00;
		endcase
	endfunction

	// ========================================
	// reference for one fetch pc.
	// ========================================

	function automatic void predict_ref(
		input  bpu_pkg::virt_t                              fpc,
		output bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0] exp_pred,
		output bpu_pkg::virt_t                              exp_next
	);
		bpu_pkg::virt_t group;
		bpu_pkg::virt_t spc;
		int             r;
		int             i;
		logic           found;
		group    = (fpc / bpu_pkg::group_bytes) * bpu_pkg::group_bytes;
		exp_next = group + bpu_pkg::group_bytes;
		found    = 1'b0;
		for (int s = 0; s < bpu_pkg::fetch_num; s++) begin
			spc = group + (s << bpu_pkg::inst_offset);
			r   = hist_row(spc);
			i   = btb_index(spc);
			exp_pred[s].hit    = tgt_valid[i] && (tgt_tag[i] == btb_tag(spc));
			exp_pred[s].target = tgt_addr[i];
			exp_pred[s].taken  = hist_valid[r][s] && hist_cnt[r][s][1] && exp_pred[s].hit;
			if (exp_pred[s].taken && !found) begin
				exp_next = exp_pred[s].target;   // lowest taken slot.
				found    = 1'b1;
			end
		end
	endfunction

	task automatic compare_outputs();
		bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0] exp_pred;
		bpu_pkg::virt_t                                   exp_next;
		logic [bpu_pkg::update_sources-1:0]               exp_ready;
		predict_ref(pc, exp_pred, exp_next);
		for (int s = 0; s < bpu_pkg::fetch_num; s++) begin
			if (predict[s].hit !== exp_pred[s].hit || predict[s].taken !== exp_pred[s].taken
				|| (exp_pred[s].hit && predict[s].target !== exp_pred[s].target)) begin
				n_pred++;
				$display({"CHECK FAILED %0t: pc %h slot %0d hit %b taken %b target %h,",
					" expected %b %b %h"},
					$time, pc, s, predict[s].hit, predict[s].taken, predict[s].target,
					exp_pred[s].hit, exp_pred[s].taken, exp_pred[s].target);
			end
		end
		if (next_pc !== exp_next) begin
			n_pred++;
			$display("CHECK FAILED %0t: pc %h next_pc %h, expected %h",
				$time, pc, next_pc, exp_next);
		end
		exp_ready = (&upd_valid) ? (prio ? 2'b10 : 2'b01) : upd_valid;
		if (upd_ready !== exp_ready) begin
			n_ready++;
			$display("CHECK FAILED %0t: upd_ready %b for upd_valid %b, expected %b",
				$time, upd_ready, upd_valid, exp_ready);
		end
	endtask

	task automatic apply_updates();
		bpu_pkg::branch_update_t u;
		int                      r;
		int                      s;
		int                      i;
		if (&upd_valid) begin
			prio = ~prio;
		end
		for (int k = 0; k < bpu_pkg::update_sources; k++) begin
			if (upd_valid[k] && upd_ready[k]) begin
				u = upd[k];
				r = hist_row(u.pc);
				s = int'((u.pc >> bpu_pkg::inst_offset) % bpu_pkg::fetch_num);
				i = btb_index(u.pc);
				if (!flush) begin
					hist_valid[r][s] = 1'b1;
					hist_cnt[r][s]   = train(hist_cnt[r][s], u.taken);
				end
				if (u.taken) begin
					tgt_valid[i] = 1'b1;
					tgt_tag[i]   = btb_tag(u.pc);
					tgt_addr[i]  = u.target;
				end
			end
		end
		if (flush) begin
			for (r = 0; r < hist_rows; r++) begin
				for (s = 0; s < bpu_pkg::fetch_num; s++) begin
					hist_valid[r][s] = 1'b0;
					hist_cnt[r][s]   = 2'b10;
				end
			end
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < hist_rows; r++) begin
				for (int s = 0; s < bpu_pkg::fetch_num; s++) begin
					hist_valid[r][s] = 1'b0;
					hist_cnt[r][s]   = 2'b00;
				end
			end
			for (int i = 0; i < bpu_pkg::btb_entries; i++) begin
				tgt_valid[i] = 1'b0;
			end
			prio = 1'b0;
		end else begin
			compare_outputs();   // old state first.
			apply_updates();
		end
	end

endmodule

// ==== verif/branch_predictor_properties.sv ====
module branch_predictor_properties (
	input logic                                                  clk,
	input logic                                                  rst_n,
	input logic                                                  flush,
	input logic [bpu_pkg::update_sources-1:0]                    upd_valid,
	input logic [bpu_pkg::update_sources-1:0]                    upd_ready,
	input bpu_pkg::branch_update_t [bpu_pkg::update_sources-1:0] upd,
	input logic                                                  win_valid,
	input bpu_pkg::branch_update_t                               win,
	input bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0]      predict
);
	timeunit 1ns;
	timeprecision 100ps;

	// ========================================
	// arbiter handshake.
	// ========================================

	one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(upd_ready)) else $error("more than one source granted in a cycle");

	grant_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		(upd_ready & ~upd_valid) == '0) else $error("ready given to an idle source");

	request_served: assert property (@(posedge clk) disable iff (!rst_n)
		(|upd_valid) |-> (|upd_ready)) else $error("a request went without any grant");

	// two sources that keep asking take turns.
	take_turns: assert property (@(posedge clk) disable iff (!rst_n)
		(&upd_valid && &$past(upd_valid)) |-> (upd_ready != $past(upd_ready)))
		else $error("waiting sources were not served in turn");

	// the shared path carries exactly the transfer of this cycle.
	winner_data: assert property (@(posedge clk) disable iff (!rst_n)
		(win_valid == |(upd_valid & upd_ready))
		&& (!(upd_valid[0] && upd_ready[0]) || win == upd[0])
		&& (!(upd_valid[1] && upd_ready[1]) || win == upd[1]))
		else $error("shared update path does not carry the accepted update");

	// ========================================
	// flush.
	// ========================================

	flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !(predict[0].taken || predict[1].taken))
		else $error("a slot is predicted taken right after a flush");

endmodule

bind branch_predictor branch_predictor_properties u_properties (
	.clk       (clk),
	.rst_n     (rst_n),
	.flush     (flush),
	.upd_valid (upd_valid),
	.upd_ready (upd_ready),
	.upd       (upd),
	.win_valid (win_valid),
	.win       (win),
	.predict   (predict)
);

// ==== verif/branch_predictor_tb.sv ====
module branch_predictor_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles    = 3;
	localparam int directed_cycles = 300;   // bound on the directed part.
	localparam int random_cycles   = 2000;
	localparam int timeout_ns      = (reset_cycles + directed_cycles + random_cycles + 100) * 10;

	logic                                                  clk;
	logic                                                  rst_n;
	logic                                                  flush;
	bpu_pkg::virt_t                                        pc;
	logic [bpu_pkg::update_sources-1:0]                    upd_valid;
	logic [bpu_pkg::update_sources-1:0]                    upd_ready;
	bpu_pkg::branch_update_t [bpu_pkg::update_sources-1:0] upd;
	bpu_pkg::fetch_predict_t [bpu_pkg::fetch_num-1:0]      predict;
	bpu_pkg::virt_t                                        next_pc;
	int                                                    pred_errors;
	int                                                    ready_errors;
	int                                                    stim_errors = 0;
	int                                                    held [bpu_pkg::update_sources];

	tb_clock #(.period_ns(10)) u_clock (.clk(clk));

	branch_predictor uut (.*);

	branch_predictor_checker u_checker (.*);

	// ========================================
	// stimulus helpers.
	// ========================================

	function automatic bpu_pkg::virt_t pool_pc(input logic [31:0] r);
		bpu_pkg::virt_t a;
		a        = 32'h0004_0000;
		a[13:12] = r[1:0];
		a[7]     = r[2];   // changes the bht row and the btb tag.
		a[4:2]   = r[5:3];
		return a;
	endfunction

	function automatic bpu_pkg::virt_t rand_target();
		bpu_pkg::virt_t t;
		t      = $urandom();
		t[1:0] = 2'b00;
		return t;
	endfunction

	task automatic offer(input int src, input bpu_pkg::virt_t bpc, input logic tk,
		input bpu_pkg::virt_t tgt);
		upd[src].pc     = bpc;
		upd[src].taken  = tk;
		upd[src].target = tgt;
		upd_valid[src]  = 1'b1;
	endtask

	// the handshake is sampled on the rising edge and served requests drop on the falling one.
	task automatic step();
		logic [bpu_pkg::update_sources-1:0] acc;
		@(posedge clk);
		acc = upd_valid & upd_ready;
		for (int k = 0; k < bpu_pkg::update_sources; k++) begin
			held[k] = (upd_valid[k] && !acc[k]) ? held[k] + 1 : 0;
			if (held[k] > 1) begin
				stim_errors++;
				$display("source %0d waited more than one cycle for ready at %0t", k, $time);
			end
		end
		@(negedge clk);
		upd_valid = upd_valid & ~acc;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (upd_valid != '0 && n < 4) begin
			step();
			n++;
		end
		if (upd_valid != '0) begin
			stim_errors++;
			$display("update not accepted within 4 cycles at %0t", $time);
			upd_valid = '0;
		end
	endtask

	task automatic send(input int src, input bpu_pkg::virt_t bpc, input logic tk,
		input bpu_pkg::virt_t tgt);
		offer(src, bpc, tk, tgt);
		wait_idle();
	endtask

	task automatic show(input bpu_pkg::virt_t fpc, input int cycles);
		pc = fpc;
		repeat (cycles) step();
	endtask

	task automatic random_traffic(input int cycles);
		logic [31:0] r;
		repeat (cycles) begin
			for (int k = 0; k < bpu_pkg::update_sources; k++) begin
				r = $urandom();
				if (!upd_valid[k] && r[1:0] != 2'b00) begin
					offer(k, pool_pc($urandom()), r[3:2] != 2'b00, rand_target());
				end
			end
			r     = $urandom();
			flush = (r[4:0] == 5'd0);
			pc    = pool_pc($urandom());
			step();
		end
		flush = 1'b0;
		wait_idle();
	endtask

	// ========================================
	// test sequence.
	// ========================================

	initial begin
		void'($urandom(94));
		rst_n     = 1'b0;
		flush     = 1'b0;
		pc        = '0;
		upd_valid = '0;
		upd       = '0;
		held      = '{default: 0};
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;

		repeat (16) show(pool_pc($urandom()), 1);   // empty tables miss.

		// counter walk on slot 1 of one group.
		pc = 32'h0000_1000;
		send(0, 32'h0000_1004, 1'b1, 32'h0000_5000);
		send(1, 32'h0000_1004, 1'b1, 32'h0000_5000);
		send(0, 32'h0000_1004, 1'b0, 32'h0000_5000);
		send(0, 32'h0000_1004, 1'b0, 32'h0000_5000);
		send(1, 32'h0000_1004, 1'b1, 32'h0000_5000);
		send(1, 32'h0000_1004, 1'b1, 32'h0000_5000);
		show(32'h0000_1080, 2);   // aliasing tag misses.
		send(1, 32'h0000_1084, 1'b1, 32'h0000_6000);
		show(32'h0000_1000, 2);
		show(32'h0000_1080, 2);

		// both slots taken, then only slot 1.
		repeat (2) begin
			offer(0, 32'h0000_2000, 1'b1, 32'h0000_7000);
			offer(1, 32'h0000_2004, 1'b1, 32'h0000_7100);
			wait_idle();
		end
		show(32'h0000_2004, 2);
		send(0, 32'h0000_2000, 1'b0, 32'h0000_7000);
		send(0, 32'h0000_2000, 1'b0, 32'h0000_7000);
		show(32'h0000_2000, 2);

		// flush with an update in the same cycle.
		flush = 1'b1;
		offer(0, 32'h0000_3000, 1'b1, 32'h0000_8000);
		step();
		flush = 1'b0;
		show(32'h0000_2000, 2);
		show(32'h0000_3000, 2);
		send(1, 32'h0000_3000, 1'b1, 32'h0000_8000);   // weakly taken goes to strong.
		show(32'h0000_3000, 2);

		repeat (8) begin
			offer(0, pool_pc($urandom()), 1'b1, rand_target());
			offer(1, pool_pc($urandom()), 1'b1, rand_target());
			wait_idle();
		end

		random_traffic(random_cycles);
		repeat (2) step();

		$display("errors: prediction %0d, handshake %0d, stimulus %0d",
			pred_errors, ready_errors, stim_errors);
		if (pred_errors + ready_errors + stim_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog: run did not finish within %0d ns", timeout_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock #(
	parameter int period_ns = 10
)(
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule
